/* hw/dmem_params.svh */
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// Words per cache block
`define DMEM_BLOCK_WORDS 4
// Number of direct-mapped cache lines
`define DMEM_SETS 16
// Cycles from load acceptance to refill block on the controller output
`define DMEM_MC_LATENCY 4
// Backing memory size in blocks
`define DMEM_MEM_BLOCKS 64
// Default block queue depth
`define DMEM_QUEUE_DEPTH 2

// Derived address field widths, byte offset is always 2 bits
`define DMEM_OFFSET_BITS ($clog2(`DMEM_BLOCK_WORDS))
`define DMEM_LINE_BITS ($clog2(`DMEM_SETS))
`define DMEM_TAG_BITS (32 - `DMEM_LINE_BITS - `DMEM_OFFSET_BITS - 2)

`endif

/* hw/dmem_pkg.sv */
`include "dmem_params.svh"

package dmem_pkg;

    // Data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // One cache block, element i is word i of the block
    typedef logic [`DMEM_BLOCK_WORDS-1:0][31:0] block_t;

    // Front-end operation
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } memOp_t;

    // Response status
    typedef enum logic [1:0] {
        FAULT_NONE       = 2'd0,
        FAULT_ACCESS     = 2'd1,
        FAULT_ACCEL_BUSY = 2'd2
    } fault_t;

    // Block traffic towards the memory controller
    typedef enum logic {
        BLK_LOAD  = 1'b0,
        BLK_EVICT = 1'b1
    } blockOp_t;

    // Block request, data only carries a victim on an evict
    // addr is block aligned, offset bits zero
    typedef struct packed {
        blockOp_t op;
        word_t    addr;
        block_t   data;
    } blockReq_t;

endpackage

/* hw/blockQueue.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module blockQueue #(
    parameter type payload_t = dmem_pkg::block_t,
    parameter int  DEPTH     = `DMEM_QUEUE_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,
    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, no reset on payload
    payload_t          slots [DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [CNT_W-1:0]  count;
    logic              doPush;
    logic              doPop;

    // Flags come from registered occupancy only
    assign inReady  = (count != CNT_W'(DEPTH));
    assign outValid = (count != '0);
    assign outData  = slots[rdPtr];

    assign doPush = inValid && inReady;
    assign doPop  = outValid && outReady;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                // Wrap at depth, depth need not be a power of two
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= inData;
        end
    end

endmodule

/* hw/dataCache.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module dataCache (
    input  logic                                             clk,
    input  logic                                             rst,
    // Line index in the upper bits, word offset in the low bits
    input  logic [`DMEM_LINE_BITS+`DMEM_OFFSET_BITS-1:0]     index,
    input  logic [`DMEM_TAG_BITS-1:0]                        tag,
    input  logic                                             lookup,
    input  logic                                             write,
    input  logic                                             fill,
    input  dmem_pkg::word_t                                  wdata,
    input  dmem_pkg::block_t                                 fillBlock,
    output logic                                             hit,
    output logic                                             victimDirty,
    output logic [`DMEM_TAG_BITS-1:0]                        victimTag,
    output dmem_pkg::block_t                                 victimBlock,
    output dmem_pkg::word_t                                  readWord
);

    localparam int OFF_W  = `DMEM_OFFSET_BITS;
    localparam int LINE_W = `DMEM_LINE_BITS;
    localparam int TAG_W  = `DMEM_TAG_BITS;
    localparam int SETS   = `DMEM_SETS;

    // Per-line state bits, cleared by reset
    logic [SETS-1:0]        validBits;
    logic [SETS-1:0]        dirtyBits;

    // Tag and data arrays
    logic [TAG_W-1:0]       tagArray  [SETS];
    dmem_pkg::block_t       dataArray [SETS];

    logic [LINE_W-1:0]      line;
    logic [OFF_W-1:0]       offset;
    logic                   tagMatch;
    logic                   doWrite;

    // Split index into line and word offset
    assign line   = index[LINE_W+OFF_W-1:OFF_W];
    assign offset = index[OFF_W-1:0];

    assign tagMatch = validBits[line] && (tagArray[line] == tag);

    // Hit only reported on an active lookup
    assign hit = lookup && tagMatch;

    // Victim view of the addressed line
    assign victimDirty = validBits[line] && dirtyBits[line];
    assign victimTag   = tagArray[line];
    assign victimBlock = dataArray[line];

    // Read port, selected word of the addressed line
    assign readWord = dataArray[line][offset];

    // Store only lands on a hit
    assign doWrite = write && hit;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (fill) begin
                // Refilled line is valid and clean
                validBits[line] <= 1'b1;
                dirtyBits[line] <= 1'b0;
            end else if (doWrite) begin
                dirtyBits[line] <= 1'b1;
            end
        end
    end

    // Arrays carry no reset, valid bit guards them
    always_ff @(posedge clk) begin
        if (fill) begin
            tagArray[line]  <= tag;
            dataArray[line] <= fillBlock;
        end else if (doWrite) begin
            dataArray[line][offset] <= wdata;
        end
    end

endmodule

/* hw/memoryStage.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module memoryStage (
    input  logic                                         clk,
    input  logic                                         rst,
    // Front-end request
    input  logic                                         reqValid,
    output logic                                         reqReady,
    input  dmem_pkg::memOp_t                             reqOp,
    input  dmem_pkg::word_t                              reqAddr,
    input  dmem_pkg::word_t                              reqWdata,
    // Front-end response
    output logic                                         rspValid,
    input  logic                                         rspReady,
    output dmem_pkg::word_t                              rspRdata,
    output dmem_pkg::fault_t                             rspFault,
    input  logic                                         accelBusy,
    // Cache control
    output logic [`DMEM_LINE_BITS+`DMEM_OFFSET_BITS-1:0] cacheIndex,
    output logic [`DMEM_TAG_BITS-1:0]                    cacheTag,
    output logic                                         cacheLookup,
    output logic                                         cacheWrite,
    output logic                                         cacheFill,
    output dmem_pkg::word_t                              cacheWdata,
    output dmem_pkg::block_t                             cacheFillBlock,
    input  logic                                         cacheHit,
    input  logic                                         cacheVictimDirty,
    input  logic [`DMEM_TAG_BITS-1:0]                    cacheVictimTag,
    input  dmem_pkg::block_t                             cacheVictimBlock,
    input  dmem_pkg::word_t                              cacheReadWord,
    // Block requests to reqQueue
    output logic                                         pushValid,
    input  logic                                         pushReady,
    output dmem_pkg::blockReq_t                          pushData,
    // Refills from rspQueue
    input  logic                                         fillValid,
    output logic                                         fillReady,
    input  dmem_pkg::block_t                             fillBlock
);

    localparam int LOW_W = `DMEM_LINE_BITS + `DMEM_OFFSET_BITS;
    localparam int BLK_LO = `DMEM_OFFSET_BITS + 2;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, EVICT, LOAD_REQ, LOAD_WAIT, FILL, RESPOND
    } state_t;

    state_t             state;
    state_t             nextState;
    dmem_pkg::memOp_t   opQ;
    dmem_pkg::word_t    addrQ;
    dmem_pkg::word_t    wdataQ;
    dmem_pkg::word_t    rdataQ;
    dmem_pkg::fault_t   faultQ;
    dmem_pkg::fault_t   faultIn;
    logic               accept;
    logic               noFault;

    assign accept  = reqValid && reqReady;
    assign noFault = (faultQ == dmem_pkg::FAULT_NONE);

    // Address checks, busy accelerator wins over region fault
    always_comb begin
        if (accelBusy && (reqAddr[29] ^ reqAddr[28])) begin
            faultIn = dmem_pkg::FAULT_ACCEL_BUSY;
        end else if (reqAddr[31:28] != 4'd0) begin
            faultIn = dmem_pkg::FAULT_ACCESS;
        end else begin
            faultIn = dmem_pkg::FAULT_NONE;
        end
    end

    // Cache always addressed by the latched request
    assign cacheIndex     = addrQ[LOW_W+1:2];
    assign cacheTag       = addrQ[31:LOW_W+2];
    assign cacheWdata     = wdataQ;
    assign cacheFillBlock = fillBlock;
    // Faulted requests never reach the cache
    assign cacheLookup    = (state == LOOKUP) && noFault;
    assign cacheWrite     = cacheLookup && cacheHit && (opQ == dmem_pkg::MEM_WRITE);
    assign cacheFill      = (state == FILL);

    assign reqReady  = (state == IDLE);
    assign rspValid  = (state == RESPOND);
    assign rspRdata  = rdataQ;
    assign rspFault  = faultQ;
    assign pushValid = (state == EVICT) || (state == LOAD_REQ);
    // Refill is consumed in the same cycle it is written
    assign fillReady = (state == FILL);

    always_comb begin
        pushData = '0;
        if (state == EVICT) begin
            // Victim address rebuilt from its tag and line
            pushData.op   = dmem_pkg::BLK_EVICT;
            pushData.addr = {cacheVictimTag, cacheIndex[LOW_W-1:`DMEM_OFFSET_BITS],
                             BLK_LO'(0)};
            pushData.data = cacheVictimBlock;
        end else begin
            pushData.op   = dmem_pkg::BLK_LOAD;
            pushData.addr = {addrQ[31:BLK_LO], BLK_LO'(0)};
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:      if (accept) nextState = LOOKUP;
            LOOKUP: begin
                if (!noFault || cacheHit) begin
                    nextState = RESPOND;
                end else if (cacheVictimDirty) begin
                    nextState = EVICT;
                end else begin
                    nextState = LOAD_REQ;
                end
            end
            EVICT:     if (pushReady) nextState = LOAD_REQ;
            LOAD_REQ:  if (pushReady) nextState = LOAD_WAIT;
            LOAD_WAIT: if (fillValid) nextState = FILL;
            // Line is now present, redo the lookup
            FILL:      nextState = LOOKUP;
            RESPOND:   if (rspReady) nextState = IDLE;
            default:   nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            faultQ <= dmem_pkg::FAULT_NONE;
        end else begin
            state <= nextState;
            if (accept) faultQ <= faultIn;
        end
    end

    // Request payload and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            opQ    <= reqOp;
            addrQ  <= reqAddr;
            wdataQ <= reqWdata;
            rdataQ <= '0;
        end else if (cacheLookup && cacheHit && (opQ == dmem_pkg::MEM_READ)) begin
            rdataQ <= cacheReadWord;
        end
    end

endmodule

/* hw/memController.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module memController (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid,
    output logic                reqReady,
    input  dmem_pkg::blockReq_t req,
    output logic                rspValid,
    input  logic                rspReady,
    output dmem_pkg::block_t    rspBlock
);

    localparam int BLOCKS = `DMEM_MEM_BLOCKS;
    localparam int WORDS  = `DMEM_BLOCK_WORDS;
    localparam int IDX_W  = $clog2(BLOCKS);
    localparam int BLK_LO = `DMEM_OFFSET_BITS + 2;
    localparam int CNT_W  = $clog2(`DMEM_MC_LATENCY + 1);

    dmem_pkg::block_t   mem [BLOCKS];
    logic [IDX_W-1:0]   reqIdx;
    logic [IDX_W-1:0]   pendIdx;
    logic [CNT_W-1:0]   delay;
    logic               pending;
    logic               accept;

    // Block number inside the modelled memory, upper bits alias
    assign reqIdx = req.addr[BLK_LO +: IDX_W];
    assign accept = reqValid && reqReady;

    // One load at a time, evicts take a single cycle
    assign reqReady = !pending;
    assign rspValid = pending && (delay == '0);
    assign rspBlock = mem[pendIdx];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            delay   <= '0;
            pendIdx <= '0;
            // Pattern rule, word at byte address a holds a ^ 5A5A0000
            for (int b = 0; b < BLOCKS; b++) begin
                for (int w = 0; w < WORDS; w++) begin
                    mem[b][w] <= dmem_pkg::word_t'((b * WORDS + w) * 4) ^ 32'h5A5A0000;
                end
            end
        end else begin
            if (accept && (req.op == dmem_pkg::BLK_EVICT)) begin
                mem[reqIdx] <= req.data;
            end
            if (accept && (req.op == dmem_pkg::BLK_LOAD)) begin
                pending <= 1'b1;
                pendIdx <= reqIdx;
                delay   <= CNT_W'(`DMEM_MC_LATENCY);
            end else if (pending && (delay != '0)) begin
                delay <= delay - 1'b1;
            end else if (rspValid && rspReady) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

/* hw/memorySubsystem.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module memorySubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              reqValid,
    output logic              reqReady,
    input  dmem_pkg::memOp_t  reqOp,
    input  dmem_pkg::word_t   reqAddr,
    input  dmem_pkg::word_t   reqWdata,
    output logic              rspValid,
    input  logic              rspReady,
    output dmem_pkg::word_t   rspRdata,
    output dmem_pkg::fault_t  rspFault,
    input  logic              accelBusy
);

    // Stage to cache
    logic [`DMEM_LINE_BITS+`DMEM_OFFSET_BITS-1:0] cacheIndex;
    logic [`DMEM_TAG_BITS-1:0]                    cacheTag;
    logic                                         cacheLookup;
    logic                                         cacheWrite;
    logic                                         cacheFill;
    dmem_pkg::word_t                              cacheWdata;
    dmem_pkg::block_t                             cacheFillBlock;
    logic                                         cacheHit;
    logic                                         cacheVictimDirty;
    logic [`DMEM_TAG_BITS-1:0]                    cacheVictimTag;
    dmem_pkg::block_t                             cacheVictimBlock;
    dmem_pkg::word_t                              cacheReadWord;

    // Block request path, stage to controller
    logic                pushValid;
    logic                pushReady;
    dmem_pkg::blockReq_t pushData;
    logic                blkReqValid;
    logic                blkReqReady;
    dmem_pkg::blockReq_t blkReq;

    // Refill path, controller to stage
    logic                mcRspValid;
    logic                mcRspReady;
    dmem_pkg::block_t    mcRspBlock;
    logic                fillValid;
    logic                fillReady;
    dmem_pkg::block_t    fillBlock;

    memoryStage stage (
        .clk, .rst,
        .reqValid, .reqReady, .reqOp, .reqAddr, .reqWdata,
        .rspValid, .rspReady, .rspRdata, .rspFault,
        .accelBusy,
        .cacheIndex, .cacheTag, .cacheLookup, .cacheWrite, .cacheFill,
        .cacheWdata, .cacheFillBlock,
        .cacheHit, .cacheVictimDirty, .cacheVictimTag, .cacheVictimBlock,
        .cacheReadWord,
        .pushValid, .pushReady, .pushData,
        .fillValid, .fillReady, .fillBlock
    );

    dataCache cache (
        .clk, .rst,
        .index(cacheIndex), .tag(cacheTag),
        .lookup(cacheLookup), .write(cacheWrite), .fill(cacheFill),
        .wdata(cacheWdata), .fillBlock(cacheFillBlock),
        .hit(cacheHit), .victimDirty(cacheVictimDirty),
        .victimTag(cacheVictimTag), .victimBlock(cacheVictimBlock),
        .readWord(cacheReadWord)
    );

    // Evicts and loads towards memory
    blockQueue #(.payload_t(dmem_pkg::blockReq_t)) reqQueue (
        .clk, .rst,
        .inValid(pushValid), .inReady(pushReady), .inData(pushData),
        .outValid(blkReqValid), .outReady(blkReqReady), .outData(blkReq)
    );

    // Refill blocks back to the stage
    blockQueue #(.payload_t(dmem_pkg::block_t)) rspQueue (
        .clk, .rst,
        .inValid(mcRspValid), .inReady(mcRspReady), .inData(mcRspBlock),
        .outValid(fillValid), .outReady(fillReady), .outData(fillBlock)
    );

    memController mc (
        .clk, .rst,
        .reqValid(blkReqValid), .reqReady(blkReqReady), .req(blkReq),
        .rspValid(mcRspValid), .rspReady(mcRspReady), .rspBlock(mcRspBlock)
    );

endmodule

/* tb/memorySubsystem_assert.sv */
`timescale 1ns/1ps

module memorySubsystem_assert (
    input logic                clk,
    input logic                rst,
    input logic                reqValid,
    input logic                reqReady,
    input logic                rspValid,
    input logic                rspReady,
    input dmem_pkg::word_t     rspRdata,
    input dmem_pkg::fault_t    rspFault,
    input logic                pushValid,
    input logic                pushReady,
    input dmem_pkg::blockReq_t pushData,
    input logic                mcRspValid,
    input logic                mcRspReady,
    input dmem_pkg::block_t    mcRspBlock
);

    // Set on request acceptance, cleared when its response is taken
    logic outstanding;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (reqValid && reqReady) begin
            outstanding <= 1'b1;
        end else if (rspValid && rspReady) begin
            outstanding <= 1'b0;
        end
    end

    // Response stays up with the same payload until it is taken
    rspHeldCheck: assert property (@(posedge clk) disable iff (rst)
        rspValid && !rspReady |=> rspValid && $stable(rspRdata) && $stable(rspFault))
        else $error("response dropped or changed before rspReady");

    // Only one request in flight, through lookup, miss handling and response
    singleOutstandingCheck: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !reqReady)
        else $error("reqReady high while a request is outstanding");

    // Full reqQueue holds the stage with its block request unchanged
    reqQueueFullCheck: assert property (@(posedge clk) disable iff (rst)
        pushValid && !pushReady |=> pushValid && $stable(pushData))
        else $error("block request lost while reqQueue was full");

    // Full rspQueue holds the controller with its refill unchanged
    rspQueueFullCheck: assert property (@(posedge clk) disable iff (rst)
        mcRspValid && !mcRspReady |=> mcRspValid && $stable(mcRspBlock))
        else $error("refill block lost while rspQueue was full");

endmodule

/* tb/memorySubsystemTb.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module memorySubsystemTb;

    localparam int WAIT_LIMIT  = 200;
    localparam int BLOCK_BYTES = 4 * `DMEM_BLOCK_WORDS;

    logic               clk;
    logic               rst;
    logic               reqValid;
    logic               reqReady;
    dmem_pkg::memOp_t   reqOp;
    dmem_pkg::word_t    reqAddr;
    dmem_pkg::word_t    reqWdata;
    logic               rspValid;
    logic               rspReady;
    dmem_pkg::word_t    rspRdata;
    dmem_pkg::fault_t   rspFault;
    logic               accelBusy;

    // Reference memory holds written words only
    dmem_pkg::word_t    refMem [dmem_pkg::word_t];
    // Tag held by each cache line
    // A missing key is an invalid line
    dmem_pkg::word_t    lineTag [int];
    int                 errors;
    int                 requests;
    int                 responses;
    bit                 timedOut;

    memorySubsystem DUT (.*);

    bind memorySubsystem memorySubsystem_assert handshakeChecks (
        .clk(clk), .rst(rst), .reqValid(reqValid), .reqReady(reqReady),
        .rspValid(rspValid), .rspReady(rspReady), .rspRdata(rspRdata), .rspFault(rspFault),
        .pushValid(pushValid), .pushReady(pushReady), .pushData(pushData),
        .mcRspValid(mcRspValid), .mcRspReady(mcRspReady), .mcRspBlock(mcRspBlock)
    );

    always #10 clk = ~clk;

    // Initial pattern unless the word was written since
    function automatic dmem_pkg::word_t modelRead(dmem_pkg::word_t addr);
        if (refMem.exists(addr)) begin
            return refMem[addr];
        end
        return addr ^ 32'h5A5A0000;
    endfunction

    // Direct-mapped lookup that allocates the line on a miss
    function automatic bit touchLine(dmem_pkg::word_t addr);
        int              setIdx;
        dmem_pkg::word_t tagNum;
        bit              isHit;
        setIdx = int'((addr / BLOCK_BYTES) % `DMEM_SETS);
        tagNum = addr / (BLOCK_BYTES * `DMEM_SETS);
        isHit  = lineTag.exists(setIdx) && (lineTag[setIdx] == tagNum);
        lineTag[setIdx] = tagNum;
        return isHit;
    endfunction

    task automatic compareWord(string name, dmem_pkg::word_t got, dmem_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareFault(string name, dmem_pkg::fault_t got, dmem_pkg::fault_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic reportTimeout(string what);
        errors++;
        timedOut = 1'b1;
        $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic runRequest(dmem_pkg::memOp_t op, dmem_pkg::word_t addr,
                              dmem_pkg::word_t wdata, logic busy,
                              dmem_pkg::fault_t expFault, dmem_pkg::word_t expData);
        int waited;
        int latency;
        bit expectFast;
        reqValid  = 1'b1;
        reqOp     = op;
        reqAddr   = addr;
        reqWdata  = wdata;
        accelBusy = busy;
        waited = 0;
        while (!reqReady) begin
            if (waited == WAIT_LIMIT) begin
                reportTimeout("reqReady never rose");
                return;
            end
            nextCycle();
            waited++;
        end
        // Request transfers on this edge
        nextCycle();
        reqValid  = 1'b0;
        accelBusy = 1'b0;
        requests++;
        // Faults and hits answer one cycle after acceptance
        if (expFault != dmem_pkg::FAULT_NONE) begin
            expectFast = 1'b1;
        end else begin
            expectFast = touchLine(addr);
        end
        latency = 0;
        while (!rspValid) begin
            if (latency == WAIT_LIMIT) begin
                reportTimeout("rspValid never rose");
                return;
            end
            nextCycle();
            latency++;
        end
        if (expectFast && latency != 1) begin
            errors++;
            $display("ERROR t=%0t rspValid latency: got %0d expected 1", $time, latency);
        end else if (!expectFast && latency <= 1) begin
            errors++;
            $display("ERROR t=%0t rspValid latency: got %0d expected above 1", $time, latency);
        end
        // Random stall gaps on rspReady
        rspReady = ($urandom % 3) != 0;
        waited = 0;
        while (!rspReady) begin
            if (waited == WAIT_LIMIT) begin
                reportTimeout("rspReady stall loop did not end");
                return;
            end
            nextCycle();
            waited++;
            rspReady = ($urandom % 3) != 0;
        end
        if (!rspValid) begin
            errors++;
            $display("Response for request %0d was withdrawn during a stall", requests);
        end
        compareFault("rspFault", rspFault, expFault);
        compareWord("rspRdata", rspRdata, expData);
        nextCycle();
        rspReady = 1'b0;
        responses++;
        if (rspValid) begin
            errors++;
            $display("Second response seen for request %0d", requests);
        end
        if (op == dmem_pkg::MEM_WRITE && expFault == dmem_pkg::FAULT_NONE) begin
            refMem[addr] = wdata;
        end
    endtask

    initial begin
        int              fd;
        int              fields;
        string           line;
        dmem_pkg::word_t fOp;
        dmem_pkg::word_t fAddr;
        dmem_pkg::word_t fWdata;
        dmem_pkg::word_t fBusy;
        dmem_pkg::word_t fFault;
        dmem_pkg::word_t fData;
        clk       = 1'b0;
        rst       = 1'b1;
        reqValid  = 1'b0;
        reqOp     = dmem_pkg::MEM_READ;
        reqAddr   = '0;
        reqWdata  = '0;
        rspReady  = 1'b0;
        accelBusy = 1'b0;
        errors    = 0;
        requests  = 0;
        responses = 0;
        timedOut  = 1'b0;
        void'($urandom(32'he3));
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("tb/memStimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file tb/memStimulus.txt");
        end else begin
            while (!timedOut && $fgets(line, fd) != 0) begin
                // Blank and comment lines
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %h %h",
                                 fOp, fAddr, fWdata, fBusy, fFault, fData);
                if (fields != 6) begin
                    errors++;
                    $display("Stimulus line could not be parsed: %s", line);
                    continue;
                end
                // File expectation must agree with the live reference model
                if (fOp[0] == 1'b0 && fFault == 0 && fData !== modelRead(fAddr)) begin
                    errors++;
                    $display("Stimulus expects %h at %h but the reference model holds %h",
                             fData, fAddr, modelRead(fAddr));
                end
                runRequest(dmem_pkg::memOp_t'(fOp[0]), fAddr, fWdata, fBusy[0],
                           dmem_pkg::fault_t'(fFault[1:0]), fData);
            end
            $fclose(fd);
        end
        if (responses != requests) begin
            errors++;
            $display("Response count %0d does not match request count %0d", responses, requests);
        end
        $display("Requests %0d, responses %0d, errors %0d", requests, responses, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb/memStimulus.txt */
# Columns: op (0 read, 1 write), address, write data, accelBusy, fault, read data (all hex)
# Fault: 0 none, 1 access, 2 accelerator busy
0 00000010 00000000 0 0 5A5A0010
0 00000024 00000000 0 0 5A5A0024
1 00000014 CAFE0001 0 0 00000000
0 00000014 00000000 0 0 CAFE0001
0 00000114 00000000 0 0 5A5A0114
0 00000014 00000000 0 0 CAFE0001
0 80000000 00000000 0 1 00000000
0 30000000 00000000 1 1 00000000
1 10000040 DEADBEEF 1 2 00000000
0 10000040 00000000 0 1 00000000
0 00000040 00000000 0 0 5A5A0040
1 000003F0 12345678 0 0 00000000
0 000003F0 00000000 0 0 12345678
0 000000F4 00000000 0 0 5A5A00F4
0 000003F0 00000000 0 0 12345678
1 00000024 11112222 0 0 00000000
0 00000020 00000000 0 0 5A5A0020
0 00000024 00000000 0 0 11112222

/* flist.f */
+incdir+hw
hw/dmem_pkg.sv
hw/blockQueue.sv
hw/dataCache.sv
hw/memoryStage.sv
hw/memController.sv
hw/memorySubsystem.sv
tb/memorySubsystem_assert.sv
tb/memorySubsystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run with Verilator, pass only if the pass message is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module memorySubsystemTb -f flist.f -o memTbSim \
    && ./obj_dir/memTbSim | tee /dev/stderr | grep -F "Simulation completed successfully" > /dev/null \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL, pass message not found"; exit 1; }
